//--- cache_ctrl.sv
`timescale 1ns/1ps
module cache_ctrl
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              valid,
  input  logic                              op,
  input  logic [31:0]                       addr,
  input  logic [3:0]                        wstrb,
  input  logic [31:0]                       wdata,
  input  logic                              hit,
  input  logic                              hit_way,
  input  logic                              victim_valid,
  input  logic                              victim_dirty,
  input  logic [TAG_W-1:0]                  victim_tag,
  input  logic                              victim_way,
  input  logic [LINE_W-1:0]                 victim_line,
  input  logic [31:0]                       load_word,
  input  logic                              rd_rdy,
  input  logic                              ret_valid,
  input  logic                              ret_last,
  input  logic [31:0]                       ret_data,
  input  logic                              wr_rdy,
  output logic                              addr_ok,
  output logic                              data_ok,
  output logic [31:0]                       rdata,
  output logic                              rd_req,
  output logic [2:0]                        rd_type,
  output logic [31:0]                       rd_addr,
  output logic                              wr_req,
  output logic [2:0]                        wr_type,
  output logic [31:0]                       wr_addr,
  output logic [3:0]                        wr_wstrb,
  output logic [LINE_W-1:0]                 wr_data,
  output logic [INDEX_W-1:0]                lookup_index,
  output logic                              tag_we,
  output logic                              tag_way,
  output logic [TAG_W-1:0]                  tag_wr,
  output logic                              dirty_set,
  output logic                              dirty_val,
  output logic                              data_we,
  output logic                              data_way,
  output logic [INDEX_W-1:0]                data_index,
  output logic [$clog2(WORDS_PER_LINE)-1:0] data_word,
  output logic [3:0]                        data_strb,
  output logic [31:0]                       data_din
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_LOOKUP  = 3'd1;
  localparam logic [2:0] S_MISS    = 3'd2;
  localparam logic [2:0] S_REPLACE = 3'd3;
  localparam logic [2:0] S_REFILL  = 3'd4;

  logic [2:0] state;
  addr_u cpu_addr;
  addr_u req_addr;  // request register
  logic req_op;
  logic [3:0] req_wstrb;
  logic [31:0] req_wdata;
  logic victim_q;  // way picked when the miss was seen
  logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt;
  logic [$clog2(WORDS_PER_LINE)-1:0] req_word;
  logic accept;
  logic store_hit;
  logic refill_beat;
  logic victim_wb;
  logic [31:0] merged;

  assign cpu_addr.raw = addr;
  assign req_word     = req_addr.f.offset[OFFSET_W-1:2];
  assign accept       = valid && addr_ok;
  assign store_hit    = (state == S_LOOKUP) && hit && req_op;
  assign refill_beat  = (state == S_REFILL) && ret_valid;
  assign victim_wb    = victim_valid && victim_dirty;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= S_IDLE;
      req_op   <= 1'b0;
      victim_q <= 1'b0;
      beat_cnt <= '0;
      wr_req   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            state  <= S_LOOKUP;
            req_op <= op;
          end
        end
        S_LOOKUP: begin
          if (hit) begin
            state <= S_IDLE;
          end else begin
            state    <= S_MISS;
            victim_q <= victim_way;
          end
        end
        S_MISS: begin
          // a clean victim needs no write-back slot
          if (!victim_wb || wr_rdy) begin
            state  <= S_REPLACE;
            wr_req <= victim_wb;
          end
        end
        S_REPLACE: begin
          wr_req <= 1'b0;  // single-cycle pulse
          if (rd_rdy) begin
            state    <= S_REFILL;
            beat_cnt <= '0;
          end
        end
        S_REFILL: begin
          if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (ret_last) state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr.raw <= addr;
      req_wstrb    <= wstrb;
      req_wdata    <= wdata;
    end
  end

  // store miss bytes land in their word as it streams in
  always_comb begin
    merged = ret_data;
    if (req_op && beat_cnt == req_word) begin
      for (int i = 0; i < 4; i++) begin
        if (req_wstrb[i]) merged[8*i +: 8] = req_wdata[8*i +: 8];
      end
    end
  end

  assign addr_ok = (state == S_IDLE);
  assign data_ok = ((state == S_LOOKUP) && hit) ||
                   (refill_beat && (req_op ? ret_last : beat_cnt == req_word));
  assign rdata   = (state == S_LOOKUP) ? load_word : ret_data;  // critical word on refill

  assign rd_req   = (state == S_REPLACE);
  assign rd_type  = LINE_TYPE;
  assign rd_addr  = {req_addr.f.tag, req_addr.f.index, {OFFSET_W{1'b0}}};
  assign wr_type  = LINE_TYPE;
  assign wr_addr  = {victim_tag, req_addr.f.index, {OFFSET_W{1'b0}}};
  assign wr_wstrb = 4'hf;
  assign wr_data  = victim_line;

  // read the incoming set while idle, the held one otherwise
  assign lookup_index = addr_ok ? cpu_addr.f.index : req_addr.f.index;

  assign tag_we    = refill_beat && ret_last;
  assign tag_way   = (state == S_LOOKUP) ? hit_way : victim_q;
  assign tag_wr    = req_addr.f.tag;
  assign dirty_set = store_hit || (refill_beat && ret_last);
  assign dirty_val = req_op;

  assign data_we    = store_hit || refill_beat;
  assign data_way   = (state == S_LOOKUP) ? hit_way : victim_q;
  assign data_index = req_addr.f.index;
  assign data_word  = (state == S_LOOKUP) ? req_word : beat_cnt;
  assign data_strb  = store_hit ? req_wstrb : 4'hf;
  assign data_din   = (state == S_LOOKUP) ? req_wdata : merged;

endmodule

//--- cache_geom_pkg.sv
package cache_geom_pkg;

  localparam int TAG_W          = 20;
  localparam int INDEX_W        = 8;
  localparam int OFFSET_W       = 4;  // byte offset inside a line
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = 32 * WORDS_PER_LINE;

  // one address word, seen either raw or split into its cache fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
    } f;
  } addr_u;

endpackage

//--- data_store.sv
`timescale 1ns/1ps
module data_store
  import cache_geom_pkg::*;
#(
  parameter int SETS = 256
) (
  input  logic                              clk,
  input  logic [INDEX_W-1:0]                lookup_index,
  input  logic [$clog2(WORDS_PER_LINE)-1:0] lookup_word,
  input  logic                              hit_way,
  input  logic                              victim_way,
  input  logic                              data_we,
  input  logic                              data_way,
  input  logic [INDEX_W-1:0]                data_index,
  input  logic [$clog2(WORDS_PER_LINE)-1:0] data_word,
  input  logic [3:0]                        data_strb,
  input  logic [31:0]                       data_din,
  output logic [31:0]                       load_word,
  output logic [LINE_W-1:0]                 victim_line
);

  localparam int WORD_BITS = $clog2(WORDS_PER_LINE);

  logic [31:0] rd_word [2][WORDS_PER_LINE];  // registered bank outputs
  logic [WORD_BITS-1:0] word_q;

  // one word bank per way and word position
  for (genvar w = 0; w < 2; w++) begin : g_way
    for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
      logic [31:0] mem [SETS];
      logic [31:0] rd_q;
      logic bank_we;

      assign bank_we = data_we && (data_way == 1'(w)) && (data_word == WORD_BITS'(b));

      always_ff @(posedge clk) begin
        if (bank_we) begin
          for (int i = 0; i < 4; i++) begin
            if (data_strb[i]) mem[data_index][8*i +: 8] <= data_din[8*i +: 8];
          end
        end
        rd_q <= mem[lookup_index];
      end

      assign rd_word[w][b] = rd_q;
    end
  end

  always_ff @(posedge clk) begin
    word_q <= lookup_word;  // follows the read by one cycle
  end

  assign load_word = rd_word[hit_way][word_q];

  always_comb begin
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      victim_line[32*b +: 32] = rd_word[victim_way][b];
    end
  end

endmodule

//--- dcache_assertions.sv
`timescale 1ns/1ps
module dcache_assertions (
  input logic clk,
  input logic resetn,
  input logic addr_ok,
  input logic data_ok,
  input logic rd_req,
  input logic rd_rdy,
  input logic wr_req
);

  // write-back request is a single-cycle pulse
  wr_req_pulse: assert property (@(posedge clk) disable iff (!resetn) wr_req |=> !wr_req)
    else $error("wr_req stayed high for more than one cycle");

  rd_req_hold: assert property (@(posedge clk) disable iff (!resetn)
    (rd_req && !rd_rdy) |=> rd_req)
    else $error("rd_req dropped before rd_rdy was seen");

  // a response and a new acceptance window never share a cycle
  no_ok_overlap: assert property (@(posedge clk) disable iff (!resetn) !(data_ok && addr_ok))
    else $error("data_ok raised while addr_ok is high");

endmodule

bind dcache_top dcache_assertions i_assertions (
  .clk     (clk),
  .resetn  (resetn),
  .addr_ok (addr_ok),
  .data_ok (data_ok),
  .rd_req  (rd_req),
  .rd_rdy  (rd_rdy),
  .wr_req  (wr_req)
);

//--- dcache_top.sv
`timescale 1ns/1ps
module dcache_top
  import cache_geom_pkg::*;
#(
  parameter int         SETS      = 256,
  parameter logic [7:0] WAYS_SEED = 8'h59
) (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  logic              op,
  input  logic [31:0]       addr,
  input  logic [3:0]        wstrb,
  input  logic [31:0]       wdata,
  output logic              addr_ok,
  output logic              data_ok,
  output logic [31:0]       rdata,
  output logic              rd_req,
  output logic [2:0]        rd_type,
  output logic [31:0]       rd_addr,
  input  logic              rd_rdy,
  input  logic              ret_valid,
  input  logic              ret_last,
  input  logic [31:0]       ret_data,
  output logic              wr_req,
  output logic [2:0]        wr_type,
  output logic [31:0]       wr_addr,
  output logic [3:0]        wr_wstrb,
  output logic [LINE_W-1:0] wr_data,
  input  logic              wr_rdy
);

  addr_u cpu_addr;  // incoming address, split for the stores
  logic hit;
  logic hit_way;
  logic victim_valid;
  logic victim_dirty;
  logic [TAG_W-1:0] victim_tag;
  logic victim_way;
  logic way0_valid;
  logic way1_valid;
  logic [LINE_W-1:0] victim_line;
  logic [31:0] load_word;
  logic [INDEX_W-1:0] lookup_index;
  logic tag_we;
  logic tag_way;
  logic [TAG_W-1:0] tag_wr;
  logic dirty_set;
  logic dirty_val;
  logic data_we;
  logic data_way;
  logic [INDEX_W-1:0] data_index;
  logic [$clog2(WORDS_PER_LINE)-1:0] data_word;
  logic [3:0] data_strb;
  logic [31:0] data_din;

  assign cpu_addr.raw = addr;

  cache_ctrl i_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .valid        (valid),
    .op           (op),
    .addr         (addr),
    .wstrb        (wstrb),
    .wdata        (wdata),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_way   (victim_way),
    .victim_line  (victim_line),
    .load_word    (load_word),
    .rd_rdy       (rd_rdy),
    .ret_valid    (ret_valid),
    .ret_last     (ret_last),
    .ret_data     (ret_data),
    .wr_rdy       (wr_rdy),
    .addr_ok      (addr_ok),
    .data_ok      (data_ok),
    .rdata        (rdata),
    .rd_req       (rd_req),
    .rd_type      (rd_type),
    .rd_addr      (rd_addr),
    .wr_req       (wr_req),
    .wr_type      (wr_type),
    .wr_addr      (wr_addr),
    .wr_wstrb     (wr_wstrb),
    .wr_data      (wr_data),
    .lookup_index (lookup_index),
    .tag_we       (tag_we),
    .tag_way      (tag_way),
    .tag_wr       (tag_wr),
    .dirty_set    (dirty_set),
    .dirty_val    (dirty_val),
    .data_we      (data_we),
    .data_way     (data_way),
    .data_index   (data_index),
    .data_word    (data_word),
    .data_strb    (data_strb),
    .data_din     (data_din)
  );

  // outside LOOKUP the write way is the latched victim, so it also selects the victim
  tag_store #(.SETS(SETS)) i_tag (
    .clk          (clk),
    .resetn       (resetn),
    .lookup_index (lookup_index),
    .req_tag      (cpu_addr.f.tag),
    .tag_we       (tag_we),
    .tag_way      (tag_way),
    .tag_wr       (tag_wr),
    .dirty_set    (dirty_set),
    .dirty_val    (dirty_val),
    .victim_way   (tag_way),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_valid (victim_valid),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .way0_valid   (way0_valid),
    .way1_valid   (way1_valid)
  );

  data_store #(.SETS(SETS)) i_data (
    .clk          (clk),
    .lookup_index (lookup_index),
    .lookup_word  (cpu_addr.f.offset[OFFSET_W-1:2]),
    .hit_way      (hit_way),
    .victim_way   (data_way),
    .data_we      (data_we),
    .data_way     (data_way),
    .data_index   (data_index),
    .data_word    (data_word),
    .data_strb    (data_strb),
    .data_din     (data_din),
    .load_word    (load_word),
    .victim_line  (victim_line)
  );

  victim_lfsr #(.WAYS_SEED(WAYS_SEED)) i_lfsr (
    .clk        (clk),
    .resetn     (resetn),
    .way0_valid (way0_valid),
    .way1_valid (way1_valid),
    .victim_way (victim_way)
  );

endmodule

//--- dcache_trace.txt
# name op addr wstrb wdata expected_rdata hit   (all values hex, op 1 = store)
# hit 1 means data_ok must follow acceptance by one cycle, expected_rdata unused for stores
load_miss_word1      0 00001234 0 00000000 a5a5b791 0
load_hit_word1       0 00001234 0 00000000 a5a5b791 1
load_hit_word2       0 00001238 0 00000000 a5a5b79d 1
load_miss_word3      0 0000245c 0 00000000 a5a581f9 0
store_hit_low_half   1 00001238 3 deadbeef 00000000 1
load_store_hit       0 00001238 0 00000000 a5a5beef 1
store_hit_byte2      1 00001234 4 00770000 00000000 1
load_store_byte2     0 00001234 0 00000000 a577b791 1
store_miss_high_half 1 00003460 c 12345678 00000000 0
load_store_miss      0 00003460 0 00000000 123491c5 1
load_store_miss_next 0 00003468 0 00000000 a5a591cd 1
store_miss_word3     1 0000347c f cafef00d 00000000 0
load_store_word3     0 0000347c 0 00000000 cafef00d 1
evict_fill_x         1 000105a4 f 11111111 00000000 0
evict_fill_y         1 000205a8 1 000000ab 00000000 0
evict_load_z         0 000305ac 0 00000000 a5a6a009 0
reload_x_word1       0 000105a4 0 00000000 11111111 0
reload_x_word0       0 000105a0 0 00000000 a5a4a005 0
reload_y_word2       0 000205a8 0 00000000 a5a7a0ab 0
reload_y_word0       0 000205a0 0 00000000 a5a7a005 0

//--- filelist.f
cache_geom_pkg.sv
mem_bus_pkg.sv
victim_lfsr.sv
tag_store.sv
data_store.sv
cache_ctrl.sv
dcache_top.sv
dcache_assertions.sv
tb_dcache.sv

//--- mem_bus_pkg.sv
package mem_bus_pkg;

  // transfer type code for a full 16-byte line
  localparam logic [2:0] LINE_TYPE = 3'd4;

  localparam int BEATS_PER_LINE = 4;  // 32-bit refill beats per line

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f filelist.f

out=$(./obj_dir/Vtb_dcache) || true
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***'

//--- tag_store.sv
`timescale 1ns/1ps
module tag_store
  import cache_geom_pkg::*;
#(
  parameter int SETS = 256
) (
  input  logic               clk,
  input  logic               resetn,
  input  logic [INDEX_W-1:0] lookup_index,
  input  logic [TAG_W-1:0]   req_tag,
  input  logic               tag_we,
  input  logic               tag_way,
  input  logic [TAG_W-1:0]   tag_wr,
  input  logic               dirty_set,
  input  logic               dirty_val,
  input  logic               victim_way,
  output logic               hit,
  output logic               hit_way,
  output logic               victim_valid,
  output logic               victim_dirty,
  output logic [TAG_W-1:0]   victim_tag,
  output logic               way0_valid,
  output logic               way1_valid
);

  logic [TAG_W-1:0] tag_mem [2][SETS];
  logic [1:0][SETS-1:0] valid_bits;
  logic [1:0][SETS-1:0] dirty_bits;
  logic [TAG_W-1:0] tag_q [2];
  logic [1:0] valid_q;
  logic [1:0] dirty_q;
  logic [TAG_W-1:0] cmp_tag;  // tag captured with the read
  logic [1:0] way_hit;

  always_ff @(posedge clk) begin
    if (tag_we) tag_mem[tag_way][lookup_index] <= tag_wr;
    for (int w = 0; w < 2; w++) begin
      tag_q[w]   <= tag_mem[w][lookup_index];
      valid_q[w] <= valid_bits[w][lookup_index];
      dirty_q[w] <= dirty_bits[w][lookup_index];
    end
    cmp_tag <= req_tag;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (tag_we) valid_bits[tag_way][lookup_index] <= 1'b1;
      if (dirty_set) dirty_bits[tag_way][lookup_index] <= dirty_val;
    end
  end

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
    end
  end

  assign hit     = |way_hit;
  assign hit_way = way_hit[1];

  assign victim_valid = valid_q[victim_way];
  assign victim_dirty = dirty_q[victim_way];
  assign victim_tag   = tag_q[victim_way];  // rebuilds the write-back address

  assign way0_valid = valid_q[0];
  assign way1_valid = valid_q[1];

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps
module tb_dcache
  import cache_geom_pkg::*;
  import mem_bus_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic clk;
  logic resetn;
  logic valid;
  logic op;
  logic [31:0] addr;
  logic [3:0] wstrb;
  logic [31:0] wdata;
  logic addr_ok;
  logic data_ok;
  logic [31:0] rdata;
  logic rd_req;
  logic [2:0] rd_type;
  logic [31:0] rd_addr;
  logic rd_rdy = 1'b0;
  logic ret_valid = 1'b0;
  logic ret_last = 1'b0;
  logic [31:0] ret_data = '0;
  logic wr_req;
  logic [2:0] wr_type;
  logic [31:0] wr_addr;
  logic [3:0] wr_wstrb;
  logic [LINE_W-1:0] wr_data;
  logic wr_rdy = 1'b0;

  logic [LINE_W-1:0] mem_line [bit [27:0]];  // backing memory, by line address
  logic [31:0] ref_word [bit [29:0]];        // latest stored value per word
  logic [27:0] rd_line;
  logic [31:0] cur_addr = '0;                // address of the request in flight
  int beats_left;
  int rd_delay;
  int wr_delay;
  int wb_count = 0;
  int bus_errors = 0;
  int errors = 0;
  int passed = 0;
  int failed = 0;
  bit timed_out = 1'b0;
  string cur_test = "reset_values";

  dcache_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return {a[31:2], 2'b00} ^ 32'ha5a5a5a5;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] a);
    if (ref_word.exists(a[31:2])) return ref_word[a[31:2]];
    return init_word(a);
  endfunction

  function automatic logic [LINE_W-1:0] expected_line(input logic [27:0] line);
    logic [LINE_W-1:0] l;
    for (int b = 0; b < WORDS_PER_LINE; b++) begin
      l[32*b +: 32] = expected_word({line, 2'(b), 2'b00});
    end
    return l;
  endfunction

  function automatic logic [31:0] memory_word(input logic [27:0] line, input logic [1:0] b);
    if (mem_line.exists(line)) return mem_line[line][32*b +: 32];
    return init_word({line, b, 2'b00});
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] s);
    logic [31:0] m;
    m = old;
    for (int i = 0; i < 4; i++) begin
      if (s[i]) m[8*i +: 8] = d[8*i +: 8];
    end
    return m;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // memory model: delayed rd_rdy and wr_rdy, four-beat refill, write-back sink
  always @(posedge clk) begin : mem_model
    int n;
    n = 0;
    if (!resetn) begin
      rd_rdy     <= 1'b0;
      wr_rdy     <= 1'b0;
      ret_valid  <= 1'b0;
      ret_last   <= 1'b0;
      beats_left <= 0;
      rd_delay   <= $urandom % 4;
      wr_delay   <= $urandom % 4;
    end else begin
      if (rd_req && rd_rdy) begin
        if (rd_type !== LINE_TYPE) begin
          $display("CHECK FAILED %s rd_type expected %h actual %h", cur_test, LINE_TYPE, rd_type);
          n++;
        end
        if (rd_addr !== {cur_addr[31:4], 4'h0}) begin
          $display("CHECK FAILED %s rd_addr expected %h actual %h", cur_test,
                   {cur_addr[31:4], 4'h0}, rd_addr);
          n++;
        end
        rd_line    <= rd_addr[31:4];
        beats_left <= BEATS_PER_LINE;
        rd_rdy     <= 1'b0;
        rd_delay   <= $urandom % 4;
      end else if (rd_req) begin
        if (rd_delay == 0) rd_rdy <= 1'b1;
        else rd_delay <= rd_delay - 1;
      end
      if (beats_left > 0) begin
        ret_valid  <= 1'b1;
        ret_last   <= (beats_left == 1);
        ret_data   <= memory_word(rd_line, 2'(BEATS_PER_LINE - beats_left));
        beats_left <= beats_left - 1;
      end else begin
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
      end
      if (wr_req) begin
        if (wr_type !== LINE_TYPE || wr_wstrb !== 4'hf) begin
          $display("CHECK FAILED %s wr_type/wr_wstrb expected %h/f actual %h/%h",
                   cur_test, LINE_TYPE, wr_type, wr_wstrb);
          n++;
        end
        // victim shares the set of the missing request, line aligned
        if (wr_addr[11:0] !== {cur_addr[11:4], 4'h0}) begin
          $display("CHECK FAILED %s wr_addr set expected %h actual %h", cur_test,
                   {cur_addr[11:4], 4'h0}, wr_addr[11:0]);
          n++;
        end
        if (wr_data !== expected_line(wr_addr[31:4])) begin
          $display("CHECK FAILED %s wr_data expected %h actual %h",
                   cur_test, expected_line(wr_addr[31:4]), wr_data);
          n++;
        end
        mem_line[wr_addr[31:4]] = wr_data;
        wb_count <= wb_count + 1;
        wr_rdy   <= 1'b0;
        wr_delay <= $urandom % 4;
      end else if (!wr_rdy) begin
        if (wr_delay == 0) wr_rdy <= 1'b1;
        else wr_delay <= wr_delay - 1;
      end
    end
    bus_errors <= bus_errors + n;
  end

  // one CPU request, returns read data and cycles from acceptance to data_ok
  task automatic issue_request(input logic is_store, input logic [31:0] a, input logic [3:0] s,
                               input logic [31:0] d, output logic [31:0] got, output int lat);
    int n;
    got = '0;
    lat = 0;
    cur_addr = a;
    valid <= 1'b1;
    op    <= is_store;
    addr  <= a;
    wstrb <= s;
    wdata <= d;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!addr_ok && n < TIMEOUT);
    valid <= 1'b0;
    if (!addr_ok) begin
      $display("ERROR: %s was not accepted within %0d cycles", cur_test, TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    do begin
      @(posedge clk);
      lat++;
    end while (!data_ok && lat < TIMEOUT);
    if (!data_ok) begin
      $display("ERROR: %s got no data_ok within %0d cycles", cur_test, TIMEOUT);
      timed_out = 1'b1;
      return;
    end
    got = rdata;
  endtask

  initial begin
    int fd;
    int n;
    int lat;
    int err_before;
    int bus_before;
    string line;
    string name;
    logic [31:0] t_op;
    logic [31:0] t_addr;
    logic [31:0] t_strb;
    logic [31:0] t_wdata;
    logic [31:0] t_exp;
    logic [31:0] t_hit;
    logic [31:0] got;
    void'($urandom(77));
    resetn = 1'b0;
    valid  = 1'b0;
    op     = 1'b0;
    addr   = '0;
    wstrb  = '0;
    wdata  = '0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    check_value("addr_ok", 1, addr_ok);
    check_value("data_ok", 0, data_ok);
    check_value("rd_req", 0, rd_req);
    check_value("wr_req", 0, wr_req);
    if (errors == 0) passed++;
    else failed++;
    $display("%s %s", errors == 0 ? "PASS" : "FAIL", cur_test);
    fd = $fopen("dcache_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open dcache_trace.txt");
      errors++;
    end else begin
      while (!timed_out && $fgets(line, fd) > 0) begin
        if (line.len() < 2 || line[0] == "#") continue;
        n = $sscanf(line, "%s %h %h %h %h %h %h", name, t_op, t_addr, t_strb, t_wdata, t_exp,
                    t_hit);
        if (n != 7) begin
          $display("ERROR: malformed trace line: %s", line);
          errors++;
          continue;
        end
        cur_test   = name;
        err_before = errors;
        bus_before = bus_errors;
        if (t_op[0]) begin
          ref_word[t_addr[31:2]] = merge_bytes(expected_word(t_addr), t_wdata, t_strb[3:0]);
        end
        issue_request(t_op[0], t_addr, t_strb[3:0], t_wdata, got, lat);
        if (!timed_out) begin
          if (!t_op[0]) check_value("rdata", t_exp, got);
          if (t_hit[0]) check_value("latency", 1, lat);  // hit answers in LOOKUP
        end
        if (timed_out || errors != err_before || bus_errors != bus_before) begin
          failed++;
          $display("FAIL %s", name);
        end else begin
          passed++;
          $display("PASS %s", name);
        end
      end
      $fclose(fd);
    end
    cur_test = "writeback_seen";
    if (wb_count == 0) begin
      $display("ERROR: no dirty line was written back during the eviction tests");
      failed++;
      $display("FAIL %s", cur_test);
    end else begin
      passed++;
      $display("PASS %s", cur_test);
    end
    $display("tests %0d passed %0d failed %0d", passed + failed, passed, failed);
    if (failed == 0 && errors == 0 && bus_errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- victim_lfsr.sv
`timescale 1ns/1ps
module victim_lfsr #(
  parameter logic [7:0] WAYS_SEED = 8'h59
) (
  input  logic clk,
  input  logic resetn,
  input  logic way0_valid,
  input  logic way1_valid,
  output logic victim_way
);

  logic [7:0] lfsr;
  logic feedback;

  assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[3] ^ lfsr[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      lfsr <= WAYS_SEED;
    end else begin
      lfsr <= {lfsr[6:0], feedback};
    end
  end

  // fill an empty way before evicting anything
  always_comb begin
    if (!way0_valid) victim_way = 1'b0;
    else if (!way1_valid) victim_way = 1'b1;
    else victim_way = lfsr[7];  // both taken, random pick
  end

endmodule
